/* list.f */
+incdir+include
rtl/rename_pkg.sv
rtl/inst_decode.sv
rtl/tag_cam.sv
rtl/map_table.sv
rtl/free_list.sv
rtl/rename_top.sv
sim/rename_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the rename stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal -f list.f --top-module rename_tb \
	-o rename_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/rename_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Test failed" "$SIM_LOG"; then
	exit 1
fi
if ! grep -q "Test passed" "$SIM_LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0

/* sim/rename_tb.sv */
`default_nettype none
`include "rename_defines.svh"

module rename_tb;
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		rename_pkg::bundle_status_t                 status;
		rename_pkg::rename_out_t [`RN_WIDTH-1:0] result;
	} expect_t;

	logic                                    clock;
	logic                                    reset;
	logic                                    bundle_valid;
	rename_pkg::inst_word_t  [`RN_WIDTH-1:0] bundle;
	logic                    [`RN_WIDTH-1:0] cdb_valid;
	rename_pkg::phys_tag_t   [`RN_WIDTH-1:0] cdb_tag;
	logic                    [`RN_WIDTH-1:0] retire_valid;
	rename_pkg::phys_tag_t   [`RN_WIDTH-1:0] retire_tag;
	logic                                    mispredict;
	rename_pkg::bundle_status_t              status;
	rename_pkg::rename_out_t [`RN_WIDTH-1:0] result;

	// Inputs for the next cycle as set by the tests
	logic                                    nxt_bv;
	rename_pkg::inst_word_t  [`RN_WIDTH-1:0] nxt_bundle;
	logic                    [`RN_WIDTH-1:0] nxt_cv;
	rename_pkg::phys_tag_t   [`RN_WIDTH-1:0] nxt_ct;
	logic                    [`RN_WIDTH-1:0] nxt_rv;
	rename_pkg::phys_tag_t   [`RN_WIDTH-1:0] nxt_rt;
	logic                                    nxt_misp;

	// Reference copies of the live map, checkpoint and free ring
	rename_pkg::phys_tag_t m_map [`ARCH_REGS];
	logic                  m_rdy [`ARCH_REGS];
	rename_pkg::phys_tag_t c_map [`ARCH_REGS];
	logic                  c_rdy [`ARCH_REGS];
	rename_pkg::phys_tag_t m_ring [`PHYS_REGS];
	int                    m_head;
	int                    m_tail;
	int                    c_head;
	rename_pkg::phys_tag_t retire_pool [$];   // Old tags waiting to be freed

	expect_t expect_q [$];
	expect_t held;
	logic    held_valid;
	int      seed;
	int      errors;
	int      test_errors;
	int      checks;
	int      tests;

	rename_top rename_top_i (
		.clock        (clock),
		.reset        (reset),
		.bundle_valid (bundle_valid),
		.bundle       (bundle),
		.cdb_valid    (cdb_valid),
		.cdb_tag      (cdb_tag),
		.retire_valid (retire_valid),
		.retire_tag   (retire_tag),
		.mispredict   (mispredict),
		.status       (status),
		.result       (result)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic void clear_reference();
		for (int r = 0; r < `ARCH_REGS; r++) begin
			m_map[r] = rename_pkg::phys_tag_t'(r);
			m_rdy[r] = 1'b1;
			c_map[r] = rename_pkg::phys_tag_t'(r);
			c_rdy[r] = 1'b1;
		end
		for (int i = 0; i < `PHYS_REGS; i++) begin
			m_ring[i] = rename_pkg::phys_tag_t'((i + `ARCH_REGS) % `PHYS_REGS);
		end
		m_head = 0;
		m_tail = `PHYS_REGS - `ARCH_REGS;
		c_head = 0;
		retire_pool.delete();
	endfunction

	// Applies one cycle of rename rules and returns what the DUT shows a cycle later
	function automatic expect_t predict_cycle(input logic bv,
			input rename_pkg::inst_word_t [`RN_WIDTH-1:0] b,
			input logic [`RN_WIDTH-1:0] cv, input rename_pkg::phys_tag_t [`RN_WIDTH-1:0] ct,
			input logic [`RN_WIDTH-1:0] rv, input rename_pkg::phys_tag_t [`RN_WIDTH-1:0] rt,
			input logic misp);
		expect_t               e;
		logic [`RN_WIDTH-1:0]  sv;
		logic [`RN_WIDTH-1:0]  ua;
		logic [`RN_WIDTH-1:0]  ub;
		logic [`RN_WIDTH-1:0]  hd;
		logic                  branch;
		logic                  grant;
		int                    need;
		int                    k;
		rename_pkg::phys_tag_t nt;

		e = '0;
		need = 0;
		k = 0;
		branch = 1'b0;
		for (int i = 0; i < `RN_WIDTH; i++) begin
			sv[i] = bv && !(i == 1 && b[0].opcode == rename_pkg::op_branch);
			ua[i] = b[i].opcode inside {rename_pkg::op_alu_rr, rename_pkg::op_alu_ri,
				rename_pkg::op_store, rename_pkg::op_branch};
			ub[i] = b[i].opcode inside {rename_pkg::op_alu_rr, rename_pkg::op_store,
				rename_pkg::op_branch};
			hd[i] = (b[i].opcode inside {rename_pkg::op_alu_rr, rename_pkg::op_alu_ri})
				&& (b[i].dest != `ZERO_REG);
			if (sv[i] && hd[i]) need++;
			if (sv[i] && b[i].opcode == rename_pkg::op_branch) branch = 1'b1;
		end
		grant = (m_tail - m_head) >= need;
		// Wakeups land first in both the live map and the checkpoint
		for (int r = 0; r < `ARCH_REGS; r++) begin
			for (int p = 0; p < `RN_WIDTH; p++) begin
				if (cv[p] && m_map[r] == ct[p]) m_rdy[r] = 1'b1;
				if (cv[p] && c_map[r] == ct[p]) c_rdy[r] = 1'b1;
			end
		end
		if (bv && !misp) begin
			e.status.valid        = 1'b1;
			e.status.refused      = !grant;
			e.status.checkpointed = grant && branch;
		end
		if (bv && !misp && grant) begin
			for (int i = 0; i < `RN_WIDTH; i++) begin
				if (sv[i]) begin
					e.result[i].valid = 1'b1;
					if (ua[i]) begin
						e.result[i].tag_a   = m_map[b[i].src_a];
						e.result[i].ready_a = m_rdy[b[i].src_a];
					end
					if (ub[i]) begin
						e.result[i].tag_b   = m_map[b[i].src_b];
						e.result[i].ready_b = m_rdy[b[i].src_b];
					end
					if (hd[i]) begin
						nt = m_ring[(m_head + k) % `PHYS_REGS];
						e.result[i].new_tag = nt;
						e.result[i].old_tag = m_map[b[i].dest];
						retire_pool.push_back(m_map[b[i].dest]);
						m_map[b[i].dest] = nt;   // Slot 1 sees this
						m_rdy[b[i].dest] = 1'b0;
						k++;
					end
				end
			end
			m_head += need;
			if (branch) begin
				c_map  = m_map;
				c_rdy  = m_rdy;
				c_head = m_head;
			end
		end
		if (misp) begin
			m_map  = c_map;
			m_rdy  = c_rdy;
			m_head = c_head;
		end
		for (int p = 0; p < `RN_WIDTH; p++) begin
			if (rv[p]) begin
				m_ring[m_tail % `PHYS_REGS] = rt[p];
				m_tail++;
			end
		end
		return e;
	endfunction

	function automatic rename_pkg::inst_word_t make_inst(input rename_pkg::opcode_e op,
			input int d, input int a, input int b);
		rename_pkg::inst_word_t w;

		w        = '0;
		w.opcode = op;
		w.dest   = rename_pkg::arch_reg_t'(d);
		w.src_a  = rename_pkg::arch_reg_t'(a);
		w.src_b  = rename_pkg::arch_reg_t'(b);
		return w;
	endfunction

	// Small register range plus the zero register so slots collide often
	function automatic int random_reg();
		int r;

		r = $unsigned($random(seed)) % 9;
		return (r == 8) ? `ZERO_REG : r;
	endfunction

	function automatic rename_pkg::inst_word_t random_inst();
		rename_pkg::opcode_e op;

		op = rename_pkg::opcode_e'($unsigned($random(seed)) % 6);
		return make_inst(op, random_reg(), random_reg(), random_reg());
	endfunction

	// Frees pooled tags without letting the ring overflow after a restore
	function automatic void add_retires(input int n);
		int used;

		used = 0;
		for (int p = 0; p < n && p < `RN_WIDTH; p++) begin
			if (retire_pool.size() > 0 && m_tail + used + 1 - c_head <= `PHYS_REGS) begin
				nxt_rv[p] = 1'b1;
				nxt_rt[p] = retire_pool.pop_front();
				used++;
			end
		end
	endfunction

	task automatic drive_cycle();
		@(posedge clock);
		bundle_valid <= nxt_bv;
		bundle       <= nxt_bundle;
		cdb_valid    <= nxt_cv;
		cdb_tag      <= nxt_ct;
		retire_valid <= nxt_rv;
		retire_tag   <= nxt_rt;
		mispredict   <= nxt_misp;
		expect_q.push_back(predict_cycle(nxt_bv, nxt_bundle, nxt_cv, nxt_ct, nxt_rv, nxt_rt,
			nxt_misp));
		nxt_bv     = 1'b0;
		nxt_bundle = '0;
		nxt_cv     = '0;
		nxt_rv     = '0;
		nxt_misp   = 1'b0;
	endtask

	task automatic check_value(input string field, input logic [63:0] got,
			input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at time %0t: %s is %h, expected %h", $time, field, got, exp);
		end
	endtask

	task automatic finish_test(input string name);
		drive_cycle();   // Idle cycles let the last result reach the compare
		drive_cycle();
		tests++;
		$display("%s: %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	// Outputs are sampled on the falling edge one cycle behind the drive
	initial begin
		held_valid = 1'b0;
		forever begin
			@(negedge clock);
			if (held_valid) begin
				check_value("status", 64'(status), 64'(held.status));
				check_value("result[0]", 64'(result[0]), 64'(held.result[0]));
				check_value("result[1]", 64'(result[1]), 64'(held.result[1]));
			end
			held_valid = 1'b0;
			if (expect_q.size() > 0) begin
				held       = expect_q.pop_front();
				held_valid = 1'b1;
			end
		end
	end

	initial begin
		int   wait_cycles;
		logic timed_out;

		seed = 18173;
		errors = 0;
		test_errors = 0;
		checks = 0;
		tests = 0;
		reset = 1'b1;
		bundle_valid = 1'b0;
		bundle = '0;
		cdb_valid = '0;
		cdb_tag = '0;
		retire_valid = '0;
		retire_tag = '0;
		mispredict = 1'b0;
		nxt_bv = 1'b0;
		nxt_bundle = '0;
		nxt_cv = '0;
		nxt_ct = '0;
		nxt_rv = '0;
		nxt_rt = '0;
		nxt_misp = 1'b0;
		clear_reference();
		repeat (3) @(posedge clock);
		reset <= 1'b0;

		nxt_bv = 1'b1;
		nxt_bundle[0] = make_inst(rename_pkg::op_alu_rr, 1, 2, 3);
		nxt_bundle[1] = make_inst(rename_pkg::op_alu_ri, 4, 5, 0);
		drive_cycle();
		finish_test("identity map and first tags");

		nxt_bv = 1'b1;
		nxt_bundle[0] = make_inst(rename_pkg::op_alu_rr, 6, 1, 2);
		nxt_bundle[1] = make_inst(rename_pkg::op_alu_rr, 6, 6, 7);   // Same dest as slot 0
		drive_cycle();
		nxt_bv = 1'b1;
		nxt_bundle[0] = make_inst(rename_pkg::op_alu_rr, `ZERO_REG, 4, 6);
		nxt_bundle[1] = make_inst(rename_pkg::op_alu_ri, 8, `ZERO_REG, 0);
		drive_cycle();
		finish_test("in-bundle forwarding");

		nxt_cv = 2'b01;
		nxt_ct[0] = m_map[1];
		drive_cycle();
		nxt_bv = 1'b1;
		nxt_bundle[0] = make_inst(rename_pkg::op_store, 0, 1, 6);
		nxt_bundle[1] = make_inst(rename_pkg::op_alu_rr, 9, 4, 8);
		nxt_cv = 2'b11;   // Wakes sources read in this same cycle
		nxt_ct[0] = m_map[6];
		nxt_ct[1] = m_map[8];
		drive_cycle();
		finish_test("completion broadcasts");

		for (int n = 0; n < 40 && (m_tail - m_head) > 0; n++) begin
			nxt_bv = 1'b1;
			nxt_bundle[0] = make_inst(rename_pkg::op_alu_rr, 10 + n % 8, 1, 2);
			if (m_tail - m_head >= 2) nxt_bundle[1] = make_inst(rename_pkg::op_alu_ri, 20, 3, 0);
			drive_cycle();
		end
		nxt_bv = 1'b1;
		nxt_bundle[0] = make_inst(rename_pkg::op_alu_rr, 11, 1, 20);
		drive_cycle();
		nxt_bv = 1'b1;
		nxt_bundle[0] = make_inst(rename_pkg::op_alu_rr, 11, 1, 20);
		add_retires(2);   // Not usable until the next cycle
		drive_cycle();
		nxt_bv = 1'b1;
		nxt_bundle[0] = make_inst(rename_pkg::op_alu_rr, 12, 11, 20);
		nxt_bundle[1] = make_inst(rename_pkg::op_alu_rr, 13, 12, 12);
		drive_cycle();
		repeat (5) begin
			add_retires(2);
			drive_cycle();
		end
		finish_test("free list exhaustion and retire");

		nxt_bv = 1'b1;
		nxt_bundle[0] = make_inst(rename_pkg::op_alu_rr, 1, 2, 3);
		nxt_bundle[1] = make_inst(rename_pkg::op_branch, 0, 1, 4);
		drive_cycle();
		nxt_bv = 1'b1;
		nxt_bundle[0] = make_inst(rename_pkg::op_alu_rr, 1, 1, 5);
		nxt_bundle[1] = make_inst(rename_pkg::op_alu_rr, 2, 1, 1);
		nxt_cv = 2'b01;
		nxt_ct[0] = m_map[1];   // Tag saved in the checkpoint
		drive_cycle();
		nxt_bv = 1'b1;
		nxt_bundle[0] = make_inst(rename_pkg::op_alu_ri, 3, 2, 0);
		nxt_misp = 1'b1;
		drive_cycle();
		nxt_bv = 1'b1;
		nxt_bundle[0] = make_inst(rename_pkg::op_alu_rr, 5, 1, 2);
		nxt_bundle[1] = make_inst(rename_pkg::op_alu_rr, 6, 3, 1);
		drive_cycle();
		finish_test("checkpoint and mispredict");

		for (int c = 0; c < 2000; c++) begin
			if ($unsigned($random(seed)) % 4 != 0) begin
				nxt_bv = 1'b1;
				nxt_bundle[0] = random_inst();
				nxt_bundle[1] = random_inst();
				if (nxt_bundle[0].opcode == rename_pkg::op_branch
						&& nxt_bundle[1].opcode == rename_pkg::op_branch) begin
					nxt_bundle[1].opcode = rename_pkg::op_alu_rr;
				end
			end
			for (int p = 0; p < `RN_WIDTH; p++) begin
				nxt_cv[p] = $random(seed) & 1;
				nxt_ct[p] = m_map[random_reg()];
			end
			add_retires($unsigned($random(seed)) % 3);
			nxt_misp = ($unsigned($random(seed)) % 20) == 0;
			drive_cycle();
		end
		finish_test("random mix");

		wait_cycles = 0;
		while ((expect_q.size() != 0 || held_valid) && wait_cycles < 10) begin
			@(negedge clock);
			wait_cycles++;
		end
		timed_out = expect_q.size() != 0 || held_valid;
		if (timed_out) begin
			$display("Timeout: expected results were never compared with the DUT");
		end
		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/rename_top.sv */
`default_nettype none
`include "rename_defines.svh"

module rename_top (
	input  logic                                     clock,
	input  logic                                     reset,
	input  logic                                     bundle_valid,
	input  rename_pkg::inst_word_t  [`RN_WIDTH-1:0] bundle,
	input  logic                    [`RN_WIDTH-1:0] cdb_valid,
	input  rename_pkg::phys_tag_t   [`RN_WIDTH-1:0] cdb_tag,
	input  logic                    [`RN_WIDTH-1:0] retire_valid,
	input  rename_pkg::phys_tag_t   [`RN_WIDTH-1:0] retire_tag,
	input  logic                                     mispredict,
	output rename_pkg::bundle_status_t               status,
	output rename_pkg::rename_out_t [`RN_WIDTH-1:0] result
);

	rename_pkg::decoded_t    [`RN_WIDTH-1:0] dec;
	rename_pkg::phys_tag_t   [`RN_WIDTH-1:0] alloc_tag;
	rename_pkg::rename_out_t [`RN_WIDTH-1:0] rename_out;
	logic                                    grant_ok;
	logic                                    dispatch;
	logic                                    live;

	assign dispatch = bundle_valid && grant_ok;
	assign live     = bundle_valid && !mispredict;   // Bundle not dropped by a restore

	inst_decode inst_decode_i (
		.bundle       (bundle),
		.bundle_valid (bundle_valid),
		.dec          (dec)
	);

	map_table map_table_i (
		.clock      (clock),
		.reset      (reset),
		.mispredict (mispredict),
		.dispatch   (dispatch),
		.dec        (dec),
		.alloc_tag  (alloc_tag),
		.cdb_valid  (cdb_valid),
		.cdb_tag    (cdb_tag),
		.out        (rename_out)
	);

	free_list free_list_i (
		.clock        (clock),
		.reset        (reset),
		.mispredict   (mispredict),
		.dispatch     (dispatch),
		.dec          (dec),
		.retire_valid (retire_valid),
		.retire_tag   (retire_tag),
		.grant_ok     (grant_ok),
		.alloc_tag    (alloc_tag)
	);

	// Stage pipeline register
	always_ff @(posedge clock) begin
		if (reset) begin
			status <= '0;
		end else begin
			status.valid        <= live;
			status.refused      <= live && !grant_ok;
			status.checkpointed <= live && grant_ok && (dec[0].is_branch || dec[1].is_branch);
		end
	end

	always_ff @(posedge clock) begin
		result <= rename_out;   // Slot valids already cleared on refusal
	end

endmodule

`default_nettype wire

/* rtl/free_list.sv */
`default_nettype none
`include "rename_defines.svh"

module free_list (
	input  logic                                   clock,
	input  logic                                   reset,
	input  logic                                   mispredict,
	input  logic                                   dispatch,
	input  rename_pkg::decoded_t  [`RN_WIDTH-1:0] dec,
	input  logic                  [`RN_WIDTH-1:0] retire_valid,
	input  rename_pkg::phys_tag_t [`RN_WIDTH-1:0] retire_tag,
	output logic                                   grant_ok,
	output rename_pkg::phys_tag_t [`RN_WIDTH-1:0] alloc_tag
);

	// One extra pointer bit tells a full ring from an empty one
	localparam int PTR_BITS = $clog2(`PHYS_REGS) + 1;

	rename_pkg::phys_tag_t ring [`PHYS_REGS];
	logic [PTR_BITS-1:0]                 head;
	logic [PTR_BITS-1:0]                 tail;
	logic [PTR_BITS-1:0]                 count;
	logic [PTR_BITS-1:0]                 ckpt_head;
	logic [PTR_BITS-1:0]                 need_count;
	logic [PTR_BITS-1:0]                 push_count;
	logic [PTR_BITS-1:0]                 head_next;
	logic [PTR_BITS-1:0]                 tail_next;
	logic [`RN_WIDTH-1:0][PTR_BITS-1:0]  wr_ptr;
	logic                                pop;
	logic                                has_branch;

	// Tags are handed out in slot order from the head
	always_comb begin
		logic [PTR_BITS-1:0] rd_ptr;

		rd_ptr     = head;
		need_count = '0;
		has_branch = 1'b0;
		alloc_tag  = '0;
		for (int i = 0; i < `RN_WIDTH; i++) begin
			if (dec[i].valid && dec[i].has_dest) begin
				alloc_tag[i] = ring[rd_ptr[PTR_BITS-2:0]];
				rd_ptr       = rd_ptr + 1'b1;
				need_count   = need_count + 1'b1;
			end
			if (dec[i].valid && dec[i].is_branch) begin
				has_branch = 1'b1;
			end
		end
	end

	assign grant_ok = (count >= need_count);   // Registered count, so no same-cycle reuse
	assign pop      = dispatch && !mispredict;

	always_comb begin
		push_count = '0;
		for (int i = 0; i < `RN_WIDTH; i++) begin
			wr_ptr[i] = tail + push_count;
			if (retire_valid[i]) begin
				push_count = push_count + 1'b1;
			end
		end
	end

	assign head_next = pop ? (head + need_count) : head;
	assign tail_next = tail + push_count;   // Retirement continues through a mispredict

	always_ff @(posedge clock) begin
		if (reset) begin
			head      <= '0;
			tail      <= PTR_BITS'(`PHYS_REGS - `ARCH_REGS);
			count     <= PTR_BITS'(`PHYS_REGS - `ARCH_REGS);
			ckpt_head <= '0;
		end else begin
			tail <= tail_next;
			if (mispredict) begin
				head  <= ckpt_head;
				count <= tail_next - ckpt_head;
			end else begin
				head  <= head_next;
				count <= count - (head_next - head) + push_count;
				if (pop && has_branch) begin
					ckpt_head <= head_next;   // Head after this bundle's pops
				end
			end
		end
	end

	// Initial free tags follow the architectural ones
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `PHYS_REGS; i++) begin
				ring[i] <= rename_pkg::phys_tag_t'(i + `ARCH_REGS);
			end
		end else begin
			for (int i = 0; i < `RN_WIDTH; i++) begin
				if (retire_valid[i]) begin
					ring[wr_ptr[i][PTR_BITS-2:0]] <= retire_tag[i];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/map_table.sv */
`default_nettype none
`include "rename_defines.svh"

module map_table (
	input  logic                                     clock,
	input  logic                                     reset,
	input  logic                                     mispredict,
	input  logic                                     dispatch,
	input  rename_pkg::decoded_t    [`RN_WIDTH-1:0] dec,
	input  rename_pkg::phys_tag_t   [`RN_WIDTH-1:0] alloc_tag,
	input  logic                    [`RN_WIDTH-1:0] cdb_valid,
	input  rename_pkg::phys_tag_t   [`RN_WIDTH-1:0] cdb_tag,
	output rename_pkg::rename_out_t [`RN_WIDTH-1:0] out
);

	rename_pkg::map_entry_t [`ARCH_REGS-1:0] live;
	rename_pkg::map_entry_t [`ARCH_REGS-1:0] ckpt;
	rename_pkg::map_entry_t [`ARCH_REGS-1:0] live_bcast;   // Live map after this cycle's cdb
	rename_pkg::map_entry_t [`ARCH_REGS-1:0] ckpt_bcast;
	rename_pkg::map_entry_t [`ARCH_REGS-1:0] live_next;
	rename_pkg::map_entry_t [`ARCH_REGS-1:0] ckpt_next;
	rename_pkg::phys_tag_t  [`ARCH_REGS-1:0] live_tags;
	rename_pkg::phys_tag_t  [`ARCH_REGS-1:0] ckpt_tags;
	logic                   [`ARCH_REGS-1:0] live_hits;
	logic                   [`ARCH_REGS-1:0] ckpt_hits;
	logic                                    accept;
	logic                                    has_branch;

	assign accept = dispatch && !mispredict;   // Mispredict drops the bundle

	always_comb begin
		for (int r = 0; r < `ARCH_REGS; r++) begin
			live_tags[r] = live[r].tag;
			ckpt_tags[r] = ckpt[r].tag;
		end
	end

	tag_cam #(.ENTRIES(`ARCH_REGS), .PORTS(`RN_WIDTH)) live_cam_i (
		.valid  (cdb_valid),
		.tag    (cdb_tag),
		.stored (live_tags),
		.hits   (live_hits)
	);

	// The checkpoint keeps collecting wakeups so a restore loses none
	tag_cam #(.ENTRIES(`ARCH_REGS), .PORTS(`RN_WIDTH)) ckpt_cam_i (
		.valid  (cdb_valid),
		.tag    (cdb_tag),
		.stored (ckpt_tags),
		.hits   (ckpt_hits)
	);

	always_comb begin
		live_bcast = live;
		ckpt_bcast = ckpt;
		for (int r = 0; r < `ARCH_REGS; r++) begin
			live_bcast[r].ready = live[r].ready | live_hits[r];
			ckpt_bcast[r].ready = ckpt[r].ready | ckpt_hits[r];
		end
	end

	// Slots map in order, so slot 1 reads what slot 0 just wrote
	always_comb begin
		out        = '0;
		has_branch = 1'b0;
		live_next  = live_bcast;
		for (int i = 0; i < `RN_WIDTH; i++) begin
			if (accept && dec[i].valid) begin
				out[i].valid = 1'b1;
				if (dec[i].uses_a) begin
					out[i].tag_a   = live_next[dec[i].src_a].tag;
					out[i].ready_a = live_next[dec[i].src_a].ready;
				end
				if (dec[i].uses_b) begin
					out[i].tag_b   = live_next[dec[i].src_b].tag;
					out[i].ready_b = live_next[dec[i].src_b].ready;
				end
				if (dec[i].has_dest) begin
					out[i].new_tag = alloc_tag[i];
					out[i].old_tag = live_next[dec[i].dest].tag;
					live_next[dec[i].dest].tag   = alloc_tag[i];
					live_next[dec[i].dest].ready = 1'b0;   // Waits for its cdb
				end
				if (dec[i].is_branch) begin
					has_branch = 1'b1;
				end
			end
		end
		if (mispredict) begin
			live_next = ckpt_bcast;
		end
	end

	// Save the post-bundle map on a dispatched branch
	assign ckpt_next = (accept && has_branch) ? live_next : ckpt_bcast;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int r = 0; r < `ARCH_REGS; r++) begin
				live[r].tag   <= rename_pkg::phys_tag_t'(r);   // Identity map
				live[r].ready <= 1'b1;
				ckpt[r].tag   <= rename_pkg::phys_tag_t'(r);
				ckpt[r].ready <= 1'b1;
			end
		end else begin
			live <= live_next;
			ckpt <= ckpt_next;
		end
	end

endmodule

`default_nettype wire

/* rtl/tag_cam.sv */
`default_nettype none

module tag_cam #(
	parameter int ENTRIES = 32,
	parameter int PORTS   = 2
) (
	input  logic                  [PORTS-1:0]   valid,
	input  rename_pkg::phys_tag_t [PORTS-1:0]   tag,
	input  rename_pkg::phys_tag_t [ENTRIES-1:0] stored,
	output logic                  [ENTRIES-1:0] hits
);

	// Every stored tag is compared against every broadcast port
	always_comb begin
		hits = '0;
		for (int e = 0; e < ENTRIES; e++) begin
			for (int p = 0; p < PORTS; p++) begin
				if (valid[p] && (tag[p] == stored[e])) begin
					hits[e] = 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/inst_decode.sv */
`default_nettype none
`include "rename_defines.svh"

module inst_decode (
	input  rename_pkg::inst_word_t [`RN_WIDTH-1:0] bundle,
	input  logic                                    bundle_valid,
	output rename_pkg::decoded_t   [`RN_WIDTH-1:0] dec
);

	always_comb begin
		logic seen_branch;

		dec = '0;
		seen_branch = 1'b0;
		for (int i = 0; i < `RN_WIDTH; i++) begin
			dec[i].valid = bundle_valid && !seen_branch;    // Bundle ends at a branch
			dec[i].src_a = bundle[i].src_a;
			dec[i].src_b = bundle[i].src_b;
			dec[i].dest  = bundle[i].dest;

			case (bundle[i].opcode)
				rename_pkg::op_alu_rr: begin
					dec[i].uses_a   = 1'b1;
					dec[i].uses_b   = 1'b1;
					dec[i].has_dest = 1'b1;
				end
				rename_pkg::op_alu_ri: begin
					dec[i].uses_a   = 1'b1;
					dec[i].has_dest = 1'b1;
				end
				rename_pkg::op_store: begin
					dec[i].uses_a = 1'b1;   // Address base
					dec[i].uses_b = 1'b1;   // Store data
				end
				rename_pkg::op_branch: begin
					dec[i].uses_a    = 1'b1;
					dec[i].uses_b    = 1'b1;
					dec[i].is_branch = 1'b1;
				end
				default: begin
					// op_nop and unused encodings touch no registers
				end
			endcase

			// Writes to the zero register are dropped
			if (bundle[i].dest == rename_pkg::arch_reg_t'(`ZERO_REG)) begin
				dec[i].has_dest = 1'b0;
			end

			if (dec[i].valid && dec[i].is_branch) begin
				seen_branch = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/rename_pkg.sv */
`default_nettype none
`include "rename_defines.svh"

package rename_pkg;

	typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;
	typedef logic [$clog2(`PHYS_REGS)-1:0] phys_tag_t;

	// 3-bit opcode field at the top of the instruction word
	typedef enum logic [2:0] {
		op_nop    = 3'd0,
		op_alu_rr = 3'd1,
		op_alu_ri = 3'd2,
		op_store  = 3'd3,
		op_branch = 3'd4
	} opcode_e;

	typedef struct packed {
		opcode_e     opcode;
		arch_reg_t   dest;
		arch_reg_t   src_a;
		arch_reg_t   src_b;
		logic [13:0] immediate;     // Fills the word to 32 bits
	} inst_word_t;

	typedef struct packed {
		logic      valid;
		logic      uses_a;
		logic      uses_b;
		logic      has_dest;
		arch_reg_t src_a;
		arch_reg_t src_b;
		arch_reg_t dest;
		logic      is_branch;
	} decoded_t;

	typedef struct packed {
		phys_tag_t tag;
		logic      ready;
	} map_entry_t;

	// Per-slot rename result, fields are zero where unused
	typedef struct packed {
		logic      valid;
		phys_tag_t tag_a;
		logic      ready_a;
		phys_tag_t tag_b;
		logic      ready_b;
		phys_tag_t new_tag;
		phys_tag_t old_tag;
	} rename_out_t;

	typedef struct packed {
		logic valid;
		logic refused;          // Not enough free tags
		logic checkpointed;     // Bundle held a branch
	} bundle_status_t;

endpackage

`default_nettype wire

/* include/rename_defines.svh */
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Rename stage sizing

// Instruction slots per dispatch bundle
`define RN_WIDTH 2

// Architectural register file
`define ARCH_REGS 32

// Physical register file, also the depth of the free list ring
`define PHYS_REGS 64

// Hardwired register, reads are never renamed and writes allocate nothing
`define ZERO_REG 31

`endif
